//--- common/nox_fetch_defs.svh
`ifndef NOX_FETCH_DEFS_SVH
`define NOX_FETCH_DEFS_SVH

// Core bus address and data widths
`define NOX_ADDR_W 32
`define NOX_DATA_W 32

// Instructions held locally by fetch, also the outstanding read limit
`define NOX_L0_SLOTS 2

// Instruction memory size in 32-bit words
`define NOX_IMEM_WORDS 256

`endif

//--- common/nox_fetch_pkg.sv
`include "nox_fetch_defs.svh"

package nox_fetch_pkg;

  typedef logic [`NOX_ADDR_W-1:0] pc_t;
  typedef logic [`NOX_ADDR_W-1:0] cb_addr_t;
  typedef logic [`NOX_DATA_W-1:0] cb_data_t;
  typedef logic [`NOX_DATA_W-1:0] instr_raw_t;
  typedef logic [`NOX_DATA_W/8-1:0] cb_strb_t;
  typedef logic [$clog2(`NOX_IMEM_WORDS)-1:0] imem_idx_t;

  typedef enum logic [1:0] {
    CB_BYTE,
    CB_HALF,
    CB_WORD
  } cb_size_t;

  typedef enum logic [1:0] {
    CB_OKAY,
    CB_EXOKAY,
    CB_SLVERR,
    CB_DECERR
  } cb_resp_t;

  // Master to slave
  typedef struct packed {
    cb_addr_t wr_addr;
    cb_size_t wr_size;
    logic     wr_addr_valid;
    cb_data_t wr_data;
    cb_strb_t wr_strobe;
    logic     wr_data_valid;
    logic     wr_resp_ready;
    cb_addr_t rd_addr;
    cb_size_t rd_size;
    logic     rd_addr_valid;
    logic     rd_ready;
  } s_cb_mosi_t;

  // Slave to master, read side only
  typedef struct packed {
    logic     rd_addr_ready;
    cb_data_t rd_data;
    cb_resp_t rd_resp;
    logic     rd_valid;
  } s_cb_miso_t;

  typedef struct packed {
    logic active;
    pc_t  pc_addr;
    pc_t  mtval;
  } s_trap_info_t;

  // Program load port into the instruction memory
  typedef struct packed {
    logic      valid;
    imem_idx_t word_idx;
    cb_data_t  data;
  } s_load_t;

endpackage

//--- fetch/fetch.sv
`timescale 1ns/1ps

module fetch #(
  parameter int L0_BUFFER_SIZE = 2
) (
  input  logic                        clk,
  input  logic                        rst_i,
  // Core bus read side
  output nox_fetch_pkg::s_cb_mosi_t   instr_cb_mosi_o,
  input  nox_fetch_pkg::s_cb_miso_t   instr_cb_miso_i,
  input  logic                        fetch_start_i,
  input  nox_fetch_pkg::pc_t          fetch_start_addr_i,
  // Redirect from execute
  input  logic                        fetch_req_i,
  input  nox_fetch_pkg::pc_t          fetch_addr_i,
  // Decode handshake
  output logic                        fetch_valid_o,
  input  logic                        fetch_ready_i,
  output nox_fetch_pkg::instr_raw_t   fetch_instr_o,
  output nox_fetch_pkg::s_trap_info_t trap_info_o
);
  typedef logic [$clog2(L0_BUFFER_SIZE):0] buffer_t;

  typedef enum logic [1:0] {
    F_STP,
    F_REQ,
    F_CLR
  } fetch_st_t;

  // One read in flight, oldest at the FIFO head
  typedef struct packed {
    logic                    keep;
    nox_fetch_pkg::cb_addr_t addr;
  } s_ot_entry_t;

  fetch_st_t               st_ff, next_st;
  nox_fetch_pkg::pc_t      pc_ff, next_pc;
  nox_fetch_pkg::cb_addr_t req_addr_ff, next_req_addr;
  logic                    req_ff, next_req;
  logic                    fault_ff, next_fault;

  logic        addr_hs;
  logic        hold_addr;
  logic        issue_ok;
  logic        rd_ready;
  logic        rsp_hs;
  logic        rsp_live;
  logic        trap_hit;
  logic        l0_write;
  logic        l0_read;
  logic        l0_clear;
  logic        l0_full;
  logic        l0_empty;
  logic        ot_empty;
  buffer_t     ot_ocup;
  buffer_t     ot_level;
  s_ot_entry_t ot_push;
  s_ot_entry_t ot_head;

  assign addr_hs   = req_ff && instr_cb_miso_i.rd_addr_ready;
  assign hold_addr = req_ff && !instr_cb_miso_i.rd_addr_ready;
  assign l0_clear  = fetch_req_i || !fetch_start_i;
  assign ot_level  = ot_ocup + buffer_t'(addr_hs);

  // Stop taking data only when L0 has no room, drain freely otherwise
  assign rd_ready = (st_ff == F_REQ) ? !l0_full : 1'b1;
  assign rsp_hs   = instr_cb_miso_i.rd_valid && rd_ready;

  // Only reads of the current stream reach L0 or raise a trap
  assign rsp_live = rsp_hs && ot_head.keep && (st_ff == F_REQ) && !l0_clear;
  assign l0_write = rsp_live && (instr_cb_miso_i.rd_resp == nox_fetch_pkg::CB_OKAY);
  assign trap_hit = rsp_live && (instr_cb_miso_i.rd_resp != nox_fetch_pkg::CB_OKAY);

  assign issue_ok = !l0_clear && !trap_hit && !fault_ff && !l0_full &&
                    (ot_level < buffer_t'(L0_BUFFER_SIZE));

  // A read accepted during a redirect or a stop is stale from the start
  assign ot_push.keep = (st_ff == F_REQ) && !l0_clear;
  assign ot_push.addr = req_addr_ff;

  always_comb begin
    next_st       = st_ff;
    next_pc       = pc_ff;
    next_req      = hold_addr;
    next_req_addr = req_addr_ff;
    next_fault    = fault_ff || trap_hit;

    case (st_ff)
      F_STP: begin
        if (fetch_start_i && !req_ff && ot_empty) begin
          next_st = F_REQ;
        end
      end
      F_REQ: begin
        if (!hold_addr && issue_ok) begin
          next_req      = 1'b1;
          next_req_addr = pc_ff;
          next_pc       = pc_ff + nox_fetch_pkg::pc_t'(4);
        end
        if (fetch_req_i || trap_hit) begin
          next_st = F_CLR;
        end
      end
      F_CLR: begin
        // Old reads are all answered and dropped before the new stream starts
        if (!req_ff && ot_empty) begin
          next_st = F_REQ;
        end
      end
      default: next_st = F_STP;
    endcase

    if (fetch_req_i) begin
      next_pc    = fetch_addr_i;
      next_fault = 1'b0;
    end
    if (!fetch_start_i) begin
      next_st    = F_STP;
      next_fault = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      st_ff    <= F_STP;
      pc_ff    <= fetch_start_addr_i;
      req_ff   <= 1'b0;
      fault_ff <= 1'b0;
    end else begin
      st_ff    <= next_st;
      pc_ff    <= next_pc;
      req_ff   <= next_req;
      fault_ff <= next_fault;
    end
  end

  always_ff @(posedge clk) begin
    req_addr_ff <= next_req_addr;
  end

  always_comb begin
    instr_cb_mosi_o               = '0;
    instr_cb_mosi_o.rd_addr       = req_addr_ff;
    instr_cb_mosi_o.rd_size       = nox_fetch_pkg::CB_WORD;
    instr_cb_mosi_o.rd_addr_valid = req_ff;
    instr_cb_mosi_o.rd_ready      = rd_ready;
  end

  assign fetch_valid_o = !l0_clear && !l0_empty;
  assign l0_read       = fetch_valid_o && fetch_ready_i;

  // Access fault reported with the address of the failing read
  always_comb begin
    trap_info_o = '0;
    if (trap_hit) begin
      trap_info_o.active  = 1'b1;
      trap_info_o.pc_addr = ot_head.addr;
      trap_info_o.mtval   = ot_head.addr;
    end
  end

  fifo_nox #(
    .SLOTS   (L0_BUFFER_SIZE),
    .WIDTH   ($bits(s_ot_entry_t))
  ) u_fifo_ot (
    .clk     (clk),
    .rst_i   (rst_i),
    .clear_i (1'b0),
    .write_i (addr_hs),
    .read_i  (rsp_hs),
    .data_i  (ot_push),
    .data_o  (ot_head),
    .full_o  (),
    .empty_o (ot_empty),
    .ocup_o  (ot_ocup)
  );

  fifo_nox #(
    .SLOTS   (L0_BUFFER_SIZE),
    .WIDTH   ($bits(nox_fetch_pkg::instr_raw_t))
  ) u_fifo_l0 (
    .clk     (clk),
    .rst_i   (rst_i),
    .clear_i (l0_clear),
    .write_i (l0_write),
    .read_i  (l0_read),
    .data_i  (instr_cb_miso_i.rd_data),
    .data_o  (fetch_instr_o),
    .full_o  (l0_full),
    .empty_o (l0_empty),
    .ocup_o  ()
  );

endmodule

//--- nox_fetch.f
+incdir+common
common/nox_fetch_pkg.sv
verilog/fifo_nox.sv
fetch/fetch.sv
verilog/instr_mem.sv
verilog/fetch_top.sv
sim/fetch_tb.sv

//--- sim/fetch_tb.sv
`timescale 1ns/1ps
`include "nox_fetch_defs.svh"

module fetch_tb;
  localparam int          IDX_W       = $clog2(`NOX_IMEM_WORDS);
  localparam logic [31:0] LFSR_SEED   = 32'hcceb;
  localparam logic [31:0] START_ADDR  = 32'h40;
  localparam logic [31:0] MEM_END     = `NOX_IMEM_WORDS * 4;
  localparam int          N_SEQ       = 24;
  localparam int          N_BP        = 48;
  localparam int          N_JMP       = 24;
  localparam int          N_RST       = 16;
  localparam int          N_END       = 1;
  localparam int          TOTAL_INSTR = N_SEQ + N_BP + N_JMP + N_RST + N_END;
  localparam int          TIMEOUT_CYC = 20 * TOTAL_INSTR + 200;

  logic                        clk = 1'b0;
  logic                        rst_i;
  logic                        fetch_start_i;
  nox_fetch_pkg::pc_t          fetch_start_addr_i;
  logic                        fetch_req_i;
  nox_fetch_pkg::pc_t          fetch_addr_i;
  logic                        fetch_valid_o;
  logic                        fetch_ready_i;
  nox_fetch_pkg::instr_raw_t   fetch_instr_o;
  nox_fetch_pkg::s_trap_info_t trap_info_o;
  nox_fetch_pkg::s_load_t      load_i;

  nox_fetch_pkg::cb_data_t     prog [`NOX_IMEM_WORDS];
  nox_fetch_pkg::s_trap_info_t trap_exp;
  nox_fetch_pkg::pc_t          exp_pc;
  nox_fetch_pkg::pc_t          jmp_target;
  nox_fetch_pkg::pc_t          restart_target;
  logic [31:0]                 lfsr_state;
  logic                        bp_on;
  logic                        trap_armed;
  int                          stream_cnt;
  int                          trap_cnt;
  int                          cycle_cnt = 0;

  fetch_top fetch_top_inst (
    .clk                (clk),
    .rst_i              (rst_i),
    .fetch_start_i      (fetch_start_i),
    .fetch_start_addr_i (fetch_start_addr_i),
    .fetch_req_i        (fetch_req_i),
    .fetch_addr_i       (fetch_addr_i),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_ready_i      (fetch_ready_i),
    .fetch_instr_o      (fetch_instr_o),
    .trap_info_o        (trap_info_o),
    .load_i             (load_i)
  );

  always #2 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits       = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // Expected instruction word at a byte address
  function automatic nox_fetch_pkg::instr_raw_t ref_instr(input nox_fetch_pkg::pc_t pc);
    return prog[pc[IDX_W+1:2]];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic compare_instr(input string name, input nox_fetch_pkg::instr_raw_t exp,
                               input nox_fetch_pkg::instr_raw_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR @ %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic compare_trap(input string name, input nox_fetch_pkg::s_trap_info_t exp,
                              input nox_fetch_pkg::s_trap_info_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR @ %0t ns: %s expected %b/%h/%h, got %b/%h/%h", $time, name,
                          exp.active, exp.pc_addr, exp.mtval,
                          act.active, act.pc_addr, act.mtval));
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR @ %0t ns: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task automatic wait_stream(input int n);
    while (stream_cnt < n) begin
      @(posedge clk);
    end
  endtask

  // Holds the redirect for one cycle when called on a rising edge
  task automatic pulse_redirect(input nox_fetch_pkg::pc_t target);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= target;
    @(posedge clk);
    fetch_req_i  <= 1'b0;
  endtask

  always @(posedge clk) begin
    if (bp_on) begin
      fetch_ready_i <= (take_bits(1) == 32'd1);
    end else begin
      fetch_ready_i <= 1'b1;
    end
  end

  // Outputs sampled mid-cycle, where the next edge's handshake is settled
  always @(negedge clk) begin
    if (!rst_i) begin
      if (!fetch_start_i) begin
        compare_flag("fetch_valid_o", 1'b0, fetch_valid_o);
      end
      if (fetch_req_i) begin
        compare_flag("fetch_valid_o", 1'b0, fetch_valid_o);
        exp_pc     = fetch_addr_i;
        stream_cnt = 0;
      end else if (fetch_valid_o && fetch_ready_i) begin
        compare_instr("fetch_instr_o", ref_instr(exp_pc), fetch_instr_o);
        exp_pc     = exp_pc + 32'd4;
        stream_cnt = stream_cnt + 1;
      end
      if (trap_info_o.active) begin
        if (!trap_armed) begin
          abort_run("An instruction access fault was raised where none was expected");
        end else begin
          compare_trap("trap_info_o", trap_exp, trap_info_o);
          trap_cnt = trap_cnt + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYC) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC));
    end
  end

  initial begin
    rst_i              = 1'b1;
    fetch_start_i      = 1'b0;
    fetch_start_addr_i = START_ADDR;
    fetch_req_i        = 1'b0;
    fetch_addr_i       = '0;
    fetch_ready_i      = 1'b1;
    load_i             = '0;
    bp_on              = 1'b0;
    trap_armed         = 1'b0;
    exp_pc             = START_ADDR;
    stream_cnt         = 0;
    trap_cnt           = 0;
    lfsr_state         = LFSR_SEED;
    trap_exp.active    = 1'b1;
    trap_exp.pc_addr   = MEM_END;
    trap_exp.mtval     = MEM_END;

    for (int i = 0; i < `NOX_IMEM_WORDS; i++) begin
      prog[i] = take_bits(32);
    end
    // Targets leave room for the stream and its prefetch inside memory
    jmp_target     = (take_bits(7) + 32'd8) << 2;
    restart_target = (take_bits(7) + 32'd8) << 2;

    repeat (3) @(posedge clk);
    rst_i <= 1'b0;

    for (int i = 0; i < `NOX_IMEM_WORDS; i++) begin
      @(posedge clk);
      load_i.valid    <= 1'b1;
      load_i.word_idx <= i[IDX_W-1:0];
      load_i.data     <= prog[i];
    end
    @(posedge clk);
    load_i.valid <= 1'b0;

    // Idle before start while the checker watches valid and trap
    repeat (8) @(posedge clk);

    fetch_start_i <= 1'b1;
    wait_stream(N_SEQ);

    bp_on <= 1'b1;
    wait_stream(N_SEQ + N_BP);

    pulse_redirect(jmp_target);
    wait_stream(N_JMP);

    fetch_start_i <= 1'b0;
    repeat (4) @(posedge clk);
    fetch_start_i <= 1'b1;
    pulse_redirect(restart_target);
    wait_stream(N_RST);

    // Last word of memory and then a fault on the word past the end
    bp_on      <= 1'b0;
    trap_armed = 1'b1;
    pulse_redirect(MEM_END - 32'd4);
    while (trap_cnt < 1) begin
      @(posedge clk);
    end
    // Nothing more may arrive once the fault has stopped the stream
    repeat (8) @(posedge clk);

    if (stream_cnt == N_END && trap_cnt == 1) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run($sformatf(
        "Expected %0d instruction and one fault at the memory end, got %0d and %0d",
        N_END, stream_cnt, trap_cnt));
    end
  end

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/1ps
`include "nox_fetch_defs.svh"

module fetch_top (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        fetch_start_i,
  input  nox_fetch_pkg::pc_t          fetch_start_addr_i,
  input  logic                        fetch_req_i,
  input  nox_fetch_pkg::pc_t          fetch_addr_i,
  output logic                        fetch_valid_o,
  input  logic                        fetch_ready_i,
  output nox_fetch_pkg::instr_raw_t   fetch_instr_o,
  output nox_fetch_pkg::s_trap_info_t trap_info_o,
  input  nox_fetch_pkg::s_load_t      load_i
);
  // Instruction bus between fetch and memory
  nox_fetch_pkg::s_cb_mosi_t instr_cb_mosi;
  nox_fetch_pkg::s_cb_miso_t instr_cb_miso;

  fetch #(
    .L0_BUFFER_SIZE     (`NOX_L0_SLOTS)
  ) u_fetch (
    .clk                (clk),
    .rst_i              (rst_i),
    .instr_cb_mosi_o    (instr_cb_mosi),
    .instr_cb_miso_i    (instr_cb_miso),
    .fetch_start_i      (fetch_start_i),
    .fetch_start_addr_i (fetch_start_addr_i),
    .fetch_req_i        (fetch_req_i),
    .fetch_addr_i       (fetch_addr_i),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_ready_i      (fetch_ready_i),
    .fetch_instr_o      (fetch_instr_o),
    .trap_info_o        (trap_info_o)
  );

  instr_mem u_instr_mem (
    .clk                (clk),
    .rst_i              (rst_i),
    .cb_mosi_i          (instr_cb_mosi),
    .cb_miso_o          (instr_cb_miso),
    .load_i             (load_i)
  );

endmodule

//--- verilog/fifo_nox.sv
`timescale 1ns/1ps

module fifo_nox #(
  parameter int SLOTS = 2,
  parameter int WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   clear_i,
  input  logic                   write_i,
  input  logic                   read_i,
  input  logic [WIDTH-1:0]       data_i,
  output logic [WIDTH-1:0]       data_o,
  output logic                   full_o,
  output logic                   empty_o,
  output logic [$clog2(SLOTS):0] ocup_o
);
  localparam int PTR_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

  typedef logic [PTR_W-1:0]       ptr_t;
  typedef logic [$clog2(SLOTS):0] cnt_t;

  logic [WIDTH-1:0] mem [SLOTS];
  ptr_t             wr_ptr_ff;
  ptr_t             rd_ptr_ff;
  cnt_t             cnt_ff;
  logic             do_write;
  logic             do_read;

  // Pointers wrap at SLOTS, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(SLOTS - 1)) ? ptr_t'(0) : ptr_t'(ptr + 1'b1);
  endfunction

  assign full_o   = (cnt_ff == cnt_t'(SLOTS));
  assign empty_o  = (cnt_ff == cnt_t'(0));
  assign ocup_o   = cnt_ff;
  assign data_o   = mem[rd_ptr_ff];
  assign do_write = write_i && !full_o;
  assign do_read  = read_i && !empty_o;

  always_ff @(posedge clk) begin
    if (rst_i || clear_i) begin
      wr_ptr_ff <= '0;
      rd_ptr_ff <= '0;
      cnt_ff    <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_ff <= ptr_inc(wr_ptr_ff);
      end
      if (do_read) begin
        rd_ptr_ff <= ptr_inc(rd_ptr_ff);
      end
      cnt_ff <= cnt_ff + cnt_t'(do_write) - cnt_t'(do_read);
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr_ff] <= data_i;
    end
  end

endmodule

//--- verilog/instr_mem.sv
`timescale 1ns/1ps
`include "nox_fetch_defs.svh"

module instr_mem (
  input  logic                      clk,
  input  logic                      rst_i,
  input  nox_fetch_pkg::s_cb_mosi_t cb_mosi_i,
  output nox_fetch_pkg::s_cb_miso_t cb_miso_o,
  input  nox_fetch_pkg::s_load_t    load_i
);
  localparam int IDX_W = $clog2(`NOX_IMEM_WORDS);

  nox_fetch_pkg::cb_data_t  mem [`NOX_IMEM_WORDS];
  nox_fetch_pkg::cb_data_t  rsp_data_ff;
  nox_fetch_pkg::cb_resp_t  rsp_resp_ff;
  logic                     rsp_valid_ff;
  logic                     addr_ready;
  logic                     addr_hs;
  logic                     addr_ok;
  nox_fetch_pkg::imem_idx_t rd_idx;

  // Response register is free or empties in this same cycle
  assign addr_ready = !rsp_valid_ff || cb_mosi_i.rd_ready;
  assign addr_hs    = cb_mosi_i.rd_addr_valid && addr_ready;
  assign rd_idx     = cb_mosi_i.rd_addr[IDX_W+1:2];

  // Upper address bits clear means the word lies inside the array
  assign addr_ok = (cb_mosi_i.rd_addr[`NOX_ADDR_W-1:IDX_W+2] == '0) &&
                   (cb_mosi_i.rd_size == nox_fetch_pkg::CB_WORD);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_valid_ff <= 1'b0;
    end else if (addr_hs) begin
      rsp_valid_ff <= 1'b1;
    end else if (cb_mosi_i.rd_ready) begin
      rsp_valid_ff <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (addr_hs) begin
      if (addr_ok) begin
        rsp_data_ff <= mem[rd_idx];
        rsp_resp_ff <= nox_fetch_pkg::CB_OKAY;
      end else begin
        rsp_data_ff <= '0;
        rsp_resp_ff <= nox_fetch_pkg::CB_SLVERR;
      end
    end
  end

  // Program load port
  always_ff @(posedge clk) begin
    if (load_i.valid) begin
      mem[load_i.word_idx] <= load_i.data;
    end
  end

  always_comb begin
    cb_miso_o               = '0;
    cb_miso_o.rd_addr_ready = addr_ready;
    cb_miso_o.rd_data       = rsp_data_ff;
    cb_miso_o.rd_resp       = rsp_resp_ff;
    cb_miso_o.rd_valid      = rsp_valid_ff;
  end

endmodule
